// ==== design/fme_satd_pkg.sv ====
/*
 * Shared definitions for the 8x8 SATD engine
 * Bit widths of every pipeline stage, block size, rounding constants
 * and the element and row types passed between the stages
 */

package fme_satd_pkg;

    // ******************************************************************
    // Widths and sizes
    // ******************************************************************

    localparam int PIXEL_WIDTH    = 8;
    localparam int BLOCK_SIZE     = 8;
    localparam int CNT_WIDTH      = $clog2(BLOCK_SIZE);

    // Each stage grows by what its arithmetic can produce
    localparam int DIFF_WIDTH     = PIXEL_WIDTH + 1;
    localparam int HT1_WIDTH      = DIFF_WIDTH + 3;
    localparam int HT2_WIDTH      = HT1_WIDTH + 3;
    localparam int ABS_WIDTH      = HT2_WIDTH - 1;
    // 64 magnitudes per block
    localparam int SATD_SUM_WIDTH = ABS_WIDTH + 6;
    localparam int SATD_WIDTH     = SATD_SUM_WIDTH - 2;

    // Final result is (sum + 2) >> 2
    localparam int SATD_ROUND     = 2;
    localparam int SATD_SHIFT     = 2;

    // Index of the last row or column in a block
    localparam logic [CNT_WIDTH-1:0] LAST_IDX = CNT_WIDTH'(BLOCK_SIZE - 1);

    // ******************************************************************
    // Element and row types
    // ******************************************************************

    typedef logic        [PIXEL_WIDTH-1:0] pixel_t;
    typedef logic signed [DIFF_WIDTH-1:0]  diff_t;
    typedef logic signed [HT1_WIDTH-1:0]   ht1_t;
    typedef logic signed [HT2_WIDTH-1:0]   ht2_t;

    typedef pixel_t [BLOCK_SIZE-1:0] pixel_row_t;
    typedef diff_t  [BLOCK_SIZE-1:0] diff_row_t;
    typedef ht1_t   [BLOCK_SIZE-1:0] ht1_row_t;
    typedef ht2_t   [BLOCK_SIZE-1:0] ht2_row_t;

    typedef logic [SATD_WIDTH-1:0] satd_t;

endpackage

// ==== design/ht_row_if.sv ====
/*
 * Column coefficient link between the transpose buffer and the
 * accumulator: a valid level plus one set of eight 2D coefficients
 */

`timescale 1ns/1ps

interface ht_row_if import fme_satd_pkg::*; ();

    // High for the eight cycles a block is read out
    logic     valid;
    // One column set after the column butterfly
    ht2_row_t coef;

    modport source (
        output valid,
        output coef
    );

    modport sink (
        input valid,
        input coef
    );

endinterface

// ==== design/hadamard_8pt.sv ====
/*
 * Combinational 8-point Hadamard butterfly
 * Three add/subtract stages, each one bit wider than the last,
 * over a row type given as a type parameter
 */

`timescale 1ns/1ps

module hadamard_8pt import fme_satd_pkg::*; #(
    parameter type in_row_t  = diff_row_t,
    parameter type out_row_t = ht1_row_t
) (
    input  in_row_t  row_i,
    output out_row_t row_o
);

    // Element widths follow from the row types
    localparam int IN_WIDTH  = $bits(in_row_t) / BLOCK_SIZE;
    localparam int OUT_WIDTH = $bits(out_row_t) / BLOCK_SIZE;

    logic signed [IN_WIDTH-1:0]  x  [BLOCK_SIZE];
    logic signed [IN_WIDTH:0]    m1 [BLOCK_SIZE];
    logic signed [IN_WIDTH+1:0]  m2 [BLOCK_SIZE];
    logic signed [OUT_WIDTH-1:0] m3 [BLOCK_SIZE];

    always_comb begin
        for (int i = 0; i < BLOCK_SIZE; i++) begin
            x[i] = row_i[i];
        end
    end

    // ******************************************************************
    // Stage 1: pairs half a row apart
    // ******************************************************************

    always_comb begin
        for (int i = 0; i < BLOCK_SIZE / 2; i++) begin
            m1[i]                  = {x[i][IN_WIDTH-1], x[i]}
                                   + {x[i+BLOCK_SIZE/2][IN_WIDTH-1], x[i+BLOCK_SIZE/2]};
            m1[i + BLOCK_SIZE / 2] = {x[i][IN_WIDTH-1], x[i]}
                                   - {x[i+BLOCK_SIZE/2][IN_WIDTH-1], x[i+BLOCK_SIZE/2]};
        end
    end

    // ******************************************************************
    // Stage 2: pairs two apart inside each half
    // ******************************************************************

    always_comb begin
        for (int h = 0; h < BLOCK_SIZE; h += BLOCK_SIZE / 2) begin
            for (int k = 0; k < BLOCK_SIZE / 4; k++) begin
                m2[h+k]   = {m1[h+k][IN_WIDTH], m1[h+k]}
                          + {m1[h+k+2][IN_WIDTH], m1[h+k+2]};
                m2[h+k+2] = {m1[h+k][IN_WIDTH], m1[h+k]}
                          - {m1[h+k+2][IN_WIDTH], m1[h+k+2]};
            end
        end
    end

    // ******************************************************************
    // Stage 3: neighbouring pairs, sum then difference
    // ******************************************************************

    always_comb begin
        for (int i = 0; i < BLOCK_SIZE; i += 2) begin
            m3[i]   = {m2[i][IN_WIDTH+1], m2[i]} + {m2[i+1][IN_WIDTH+1], m2[i+1]};
            m3[i+1] = {m2[i][IN_WIDTH+1], m2[i]} - {m2[i+1][IN_WIDTH+1], m2[i+1]};
        end
    end

    always_comb begin
        for (int i = 0; i < BLOCK_SIZE; i++) begin
            row_o[i] = m3[i];
        end
    end

endmodule

// ==== design/transpose_buffer.sv ====
/*
 * Row butterfly, 8x8 ping-pong transpose array and column butterfly
 * Rows shift in along one axis while the previous block's columns
 * shift out along the other; the axis swaps every block
 */

`timescale 1ns/1ps

module transpose_buffer import fme_satd_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  diff_row_t diff_row_i,
    input  logic      row_valid_i,
    ht_row_if.source  col_o
);

    logic [CNT_WIDTH-1:0] write_cnt;
    logic [CNT_WIDTH-1:0] read_cnt;
    logic                 read_avail;
    // 0: rows enter along columns, 1: rows enter along rows
    logic                 flag;
    logic                 last_row;
    logic                 shift_en;

    ht1_row_t ht1_row;
    ht1_row_t col_row;
    ht1_row_t tb_q [BLOCK_SIZE];

    assign last_row = row_valid_i && (write_cnt == LAST_IDX);
    // One shift per written row or read column, both at once when overlapped
    assign shift_en = row_valid_i || read_avail;

    // ******************************************************************
    // Control counters
    // ******************************************************************

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            write_cnt <= '0;
        end else if (row_valid_i) begin
            write_cnt <= write_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            read_cnt <= '0;
        end else if (read_avail) begin
            read_cnt <= read_cnt + 1'b1;
        end
    end

    // Setting wins so back-to-back blocks keep the read window open
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            read_avail <= 1'b0;
        end else if (last_row) begin
            read_avail <= 1'b1;
        end else if (read_cnt == LAST_IDX) begin
            read_avail <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            flag <= 1'b0;
        end else if (last_row) begin
            flag <= ~flag;
        end
    end

    // ******************************************************************
    // Transpose array
    // ******************************************************************

    hadamard_8pt #(
        .in_row_t  (diff_row_t),
        .out_row_t (ht1_row_t)
    ) row_ht_i (
        .row_i (diff_row_i),
        .row_o (ht1_row)
    );

    always_ff @(posedge clk) begin
        if (shift_en) begin
            if (flag) begin
                // Whole rows move down one step
                tb_q[0] <= ht1_row;
                for (int r = 1; r < BLOCK_SIZE; r++) begin
                    tb_q[r] <= tb_q[r-1];
                end
            end else begin
                // Element r of the row enters line r and moves right
                for (int r = 0; r < BLOCK_SIZE; r++) begin
                    tb_q[r][0] <= ht1_row[r];
                    for (int c = 1; c < BLOCK_SIZE; c++) begin
                        tb_q[r][c] <= tb_q[r][c-1];
                    end
                end
            end
        end
    end

    // Far edge against the current shift direction holds one column
    always_comb begin
        for (int i = 0; i < BLOCK_SIZE; i++) begin
            col_row[i] = flag ? tb_q[BLOCK_SIZE-1][i] : tb_q[i][BLOCK_SIZE-1];
        end
    end

    hadamard_8pt #(
        .in_row_t  (ht1_row_t),
        .out_row_t (ht2_row_t)
    ) col_ht_i (
        .row_i (col_row),
        .row_o (col_o.coef)
    );

    assign col_o.valid = read_avail;

endmodule

// ==== design/satd_accum.sv ====
/*
 * Magnitude sum and block accumulation
 * Registers each column set, adds its eight absolute values,
 * accumulates eight sums and rounds the block total
 */

`timescale 1ns/1ps

module satd_accum import fme_satd_pkg::*; (
    input  logic    clk,
    input  logic    rstn,
    ht_row_if.sink  col_i,
    output satd_t   satd_o,
    output logic    satd_valid_o
);

    ht2_row_t                  coef_q;
    logic                      coef_valid_q;

    logic [HT2_WIDTH-1:0]      mag_full [BLOCK_SIZE];
    logic [ABS_WIDTH-1:0]      mag      [BLOCK_SIZE];
    logic [ABS_WIDTH:0]        sum_l1   [BLOCK_SIZE/2];
    logic [ABS_WIDTH+1:0]      sum_l2   [BLOCK_SIZE/4];
    logic [ABS_WIDTH+2:0]      sum_row;

    logic [CNT_WIDTH-1:0]      cnt;
    logic [SATD_SUM_WIDTH-1:0] acc;
    logic [SATD_SUM_WIDTH-1:0] acc_rnd;

    // ******************************************************************
    // Input register
    // ******************************************************************

    always_ff @(posedge clk) begin
        coef_q <= col_i.coef;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            coef_valid_q <= 1'b0;
        end else begin
            coef_valid_q <= col_i.valid;
        end
    end

    // ******************************************************************
    // Absolute values and adder tree
    // ******************************************************************

    // Largest 2D coefficient is 64 * 255, so the top bit of the
    // magnitude is never needed
    always_comb begin
        for (int i = 0; i < BLOCK_SIZE; i++) begin
            mag_full[i] = coef_q[i][HT2_WIDTH-1] ? -coef_q[i] : coef_q[i];
            mag[i]      = mag_full[i][ABS_WIDTH-1:0];
        end
    end

    always_comb begin
        for (int i = 0; i < BLOCK_SIZE / 2; i++) begin
            sum_l1[i] = {1'b0, mag[2*i]} + {1'b0, mag[2*i+1]};
        end
        for (int i = 0; i < BLOCK_SIZE / 4; i++) begin
            sum_l2[i] = {1'b0, sum_l1[2*i]} + {1'b0, sum_l1[2*i+1]};
        end
        sum_row = {1'b0, sum_l2[0]} + {1'b0, sum_l2[1]};
    end

    // ******************************************************************
    // Block accumulation
    // ******************************************************************

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt          <= '0;
            acc          <= '0;
            satd_valid_o <= 1'b0;
        end else begin
            satd_valid_o <= coef_valid_q && (cnt == LAST_IDX);
            if (coef_valid_q) begin
                cnt <= cnt + 1'b1;
                // First column set of a block restarts the sum
                acc <= ((cnt == '0) ? '0 : acc) + SATD_SUM_WIDTH'(sum_row);
            end
        end
    end

    // Round to nearest, then drop the low bits
    assign acc_rnd = acc + SATD_SUM_WIDTH'(SATD_ROUND);
    assign satd_o  = acc_rnd[SATD_SUM_WIDTH-1:SATD_SHIFT];

endmodule

// ==== design/fme_satd_8x8.sv ====
/*
 * Top level of the 8x8 Hadamard SATD engine
 * Pixel differences, 2D transform with transpose, magnitude sum
 */

`timescale 1ns/1ps

module fme_satd_8x8 import fme_satd_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  pixel_row_t cur_row_i,
    input  pixel_row_t ref_row_i,
    input  logic       row_valid_i,
    output satd_t      satd_o,
    output logic       satd_valid_o
);

    diff_row_t diff_row;

    // ******************************************************************
    // Difference stage
    // ******************************************************************

    // Zero-extend both pixels so the difference keeps its sign
    always_comb begin
        for (int i = 0; i < BLOCK_SIZE; i++) begin
            diff_row[i] = {1'b0, cur_row_i[i]} - {1'b0, ref_row_i[i]};
        end
    end

    // ******************************************************************
    // Transform and accumulation
    // ******************************************************************

    ht_row_if col_if_i ();

    transpose_buffer transpose_buffer_i (
        .clk         (clk),
        .rstn        (rstn),
        .diff_row_i  (diff_row),
        .row_valid_i (row_valid_i),
        .col_o       (col_if_i.source)
    );

    satd_accum satd_accum_i (
        .clk          (clk),
        .rstn         (rstn),
        .col_i        (col_if_i.sink),
        .satd_o       (satd_o),
        .satd_valid_o (satd_valid_o)
    );

endmodule

// ==== verification/fme_satd_8x8_asserts.sv ====
/*
 * Concurrent timing checks bound to the SATD top level
 * Single-cycle result pulse, fixed latency after the last row,
 * quiet outputs during reset
 */

`timescale 1ns/1ps

module fme_satd_8x8_asserts import fme_satd_pkg::*; (
    input logic  clk,
    input logic  rstn,
    input logic  row_valid_i,
    input satd_t satd_o,
    input logic  satd_valid_o
);

    // Edges from row 8 to the result pulse
    localparam int LATENCY = BLOCK_SIZE + 1;

    logic [CNT_WIDTH-1:0] row_cnt;
    logic [LATENCY:0]     last_pipe;
    logic                 last_row;
    int                   fail_cnt = 0;

    assign last_row = row_valid_i && (row_cnt == LAST_IDX);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            row_cnt   <= '0;
            last_pipe <= '0;
        end else begin
            if (row_valid_i) begin
                row_cnt <= row_cnt + 1'b1;
            end
            last_pipe <= {last_pipe[LATENCY-1:0], last_row};
        end
    end

    valid_single_a: assert property (@(posedge clk) disable iff (!rstn)
        satd_valid_o |=> !satd_valid_o)
    else begin
        $error("satd_valid_o high on two consecutive cycles");
        fail_cnt++;
    end

    // Bit LATENCY of the pipe rises on the same edge as the result valid
    valid_latency_a: assert property (@(posedge clk) disable iff (!rstn)
        satd_valid_o == last_pipe[LATENCY])
    else begin
        $error("satd_valid_o not %0d edges after the last row of a block", LATENCY);
        fail_cnt++;
    end

    reset_quiet_a: assert property (@(posedge clk)
        !rstn |-> (!satd_valid_o && satd_o == '0))
    else begin
        $error("Outputs active while rstn is low");
        fail_cnt++;
    end

endmodule

// ==== verification/fme_satd_8x8_tb.sv ====
/*
 * Testbench for the 8x8 Hadamard SATD engine
 * Clock, reset, block stimulus, 2D Hadamard reference model,
 * result checks against an expected queue, watchdog and report
 */

`timescale 1ns/1ps

module fme_satd_8x8_tb import fme_satd_pkg::*; ();

    localparam int CLK_HALF     = 4;
    localparam int CLK_PERIOD   = 2 * CLK_HALF;
    localparam int RESET_CYCLES = 16;

    // Blocks per test group
    localparam int N_IDENT      = 2;
    localparam int N_CONST      = 6;
    localparam int N_RANDOM     = 8;
    localparam int N_B2B        = 6;
    localparam int N_GAP        = 8;
    localparam int MAX_GAP      = 4;
    localparam int NUM_BLOCKS   = N_IDENT + N_CONST + N_RANDOM + N_B2B + N_GAP;

    localparam int WATCHDOG_NS  = (NUM_BLOCKS * BLOCK_SIZE + 100) * CLK_PERIOD;

    logic       clk = 1'b0;
    logic       rstn;
    pixel_row_t cur_row_i;
    pixel_row_t ref_row_i;
    logic       row_valid_i;
    satd_t      satd_o;
    logic       satd_valid_o;

    pixel_row_t cur_blk [BLOCK_SIZE];
    pixel_row_t ref_blk [BLOCK_SIZE];
    satd_t      exp_q   [$];
    satd_t      exp_val;

    integer     seed = 32'h8ed0;
    int         errors = 0;
    int         blocks_sent = 0;
    int         pulses = 0;
    int         gap;

    int         const_diffs [N_CONST] = '{1, -1, 37, -100, 255, -255};

    always #CLK_HALF clk = ~clk;

    fme_satd_8x8 fme_satd_8x8_i (
        .clk          (clk),
        .rstn         (rstn),
        .cur_row_i    (cur_row_i),
        .ref_row_i    (ref_row_i),
        .row_valid_i  (row_valid_i),
        .satd_o       (satd_o),
        .satd_valid_o (satd_valid_o)
    );

    bind fme_satd_8x8 fme_satd_8x8_asserts asserts_i (
        .clk          (clk),
        .rstn         (rstn),
        .row_valid_i  (row_valid_i),
        .satd_o       (satd_o),
        .satd_valid_o (satd_valid_o)
    );

    // ******************************************************************
    // Reference model
    // ******************************************************************

    function automatic int abs_int(input int v);
        return (v < 0) ? -v : v;
    endfunction

    // Sylvester Hadamard entry, -1 where a AND b has odd parity
    function automatic int hsign(input int a, input int b);
        return ($countones(a & b) % 2 == 1) ? -1 : 1;
    endfunction

    function automatic int model_satd();
        int d [BLOCK_SIZE][BLOCK_SIZE];
        int t [BLOCK_SIZE][BLOCK_SIZE];
        int c;
        int sum;
        sum = 0;
        for (int i = 0; i < BLOCK_SIZE; i++) begin
            for (int j = 0; j < BLOCK_SIZE; j++) begin
                d[i][j] = int'(cur_blk[i][j]) - int'(ref_blk[i][j]);
            end
        end
        // Transform along each row
        for (int i = 0; i < BLOCK_SIZE; i++) begin
            for (int k = 0; k < BLOCK_SIZE; k++) begin
                t[i][k] = 0;
                for (int j = 0; j < BLOCK_SIZE; j++) begin
                    t[i][k] += hsign(k, j) * d[i][j];
                end
            end
        end
        // Then along each column, summing magnitudes
        for (int m = 0; m < BLOCK_SIZE; m++) begin
            for (int k = 0; k < BLOCK_SIZE; k++) begin
                c = 0;
                for (int i = 0; i < BLOCK_SIZE; i++) begin
                    c += hsign(m, i) * t[i][k];
                end
                sum += abs_int(c);
            end
        end
        return (sum + SATD_ROUND) >> SATD_SHIFT;
    endfunction

    // ******************************************************************
    // Stimulus
    // ******************************************************************

    task automatic fill_random();
        for (int r = 0; r < BLOCK_SIZE; r++) begin
            for (int c = 0; c < BLOCK_SIZE; c++) begin
                cur_blk[r][c] = pixel_t'($random(seed));
                ref_blk[r][c] = pixel_t'($random(seed));
            end
        end
    endtask

    task automatic fill_identical();
        fill_random();
        for (int r = 0; r < BLOCK_SIZE; r++) begin
            ref_blk[r] = cur_blk[r];
        end
    endtask

    // Every pixel pair differs by d, base kept inside the pixel range
    task automatic fill_constant(input int d);
        int base;
        for (int r = 0; r < BLOCK_SIZE; r++) begin
            for (int c = 0; c < BLOCK_SIZE; c++) begin
                base = int'({$random(seed)} % ((1 << PIXEL_WIDTH) - abs_int(d)));
                if (d >= 0) begin
                    ref_blk[r][c] = pixel_t'(base);
                    cur_blk[r][c] = pixel_t'(base + d);
                end else begin
                    cur_blk[r][c] = pixel_t'(base);
                    ref_blk[r][c] = pixel_t'(base - d);
                end
            end
        end
    endtask

    task automatic send_block();
        for (int r = 0; r < BLOCK_SIZE; r++) begin
            @(posedge clk);
            #1;
            cur_row_i   = cur_blk[r];
            ref_row_i   = ref_blk[r];
            row_valid_i = 1'b1;
        end
        blocks_sent++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            row_valid_i = 1'b0;
        end
    endtask

    // ******************************************************************
    // Result check
    // ******************************************************************

    always @(negedge clk) begin
        if (rstn && satd_valid_o) begin
            pulses++;
            assert (exp_q.size() != 0) else begin
                $display("Result pulse arrived with no block outstanding");
                errors++;
            end
            if (exp_q.size() != 0) begin
                exp_val = exp_q.pop_front();
                assert (satd_o == exp_val) else begin
                    $display("[ERROR] satd_o expected %h actual %h", exp_val, satd_o);
                    errors++;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not complete within %0d ns", WATCHDOG_NS);
        $display("Verification failed");
        $finish;
    end

    initial begin
        cur_row_i   = '0;
        ref_row_i   = '0;
        row_valid_i = 1'b0;
        rstn        = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstn = 1'b1;

        @(negedge clk);
        assert (satd_valid_o == 1'b0) else begin
            $display("[ERROR] satd_valid_o expected 0 actual %h", satd_valid_o);
            errors++;
        end

        // Zero difference
        for (int b = 0; b < N_IDENT; b++) begin
            fill_identical();
            exp_q.push_back('0);
            send_block();
        end

        // Only the DC term survives, 64*|d| rounds to 16*|d|
        for (int b = 0; b < N_CONST; b++) begin
            fill_constant(const_diffs[b]);
            exp_q.push_back(satd_t'(16 * abs_int(const_diffs[b])));
            send_block();
        end

        for (int b = 0; b < N_RANDOM; b++) begin
            fill_random();
            exp_q.push_back(satd_t'(model_satd()));
            send_block();
            idle_cycles(1);
        end

        // No idle cycle, both transpose directions in turn
        for (int b = 0; b < N_B2B; b++) begin
            fill_random();
            exp_q.push_back(satd_t'(model_satd()));
            send_block();
        end

        for (int b = 0; b < N_GAP; b++) begin
            fill_random();
            exp_q.push_back(satd_t'(model_satd()));
            send_block();
            gap = int'({$random(seed)} % (MAX_GAP + 1));
            idle_cycles(gap);
        end
        idle_cycles(1);

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        // Window for stray pulses
        repeat (BLOCK_SIZE + 2) @(posedge clk);

        assert (pulses == blocks_sent) else begin
            $display("Saw %0d result pulses for %0d blocks sent", pulses, blocks_sent);
            errors++;
        end

        $display("Blocks %0d, results %0d, value errors %0d, assertion failures %0d",
                 blocks_sent, pulses, errors, fme_satd_8x8_i.asserts_i.fail_cnt);
        if (errors == 0 && fme_satd_8x8_i.asserts_i.fail_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
design/fme_satd_pkg.sv
design/ht_row_if.sv
design/hadamard_8pt.sv
design/transpose_buffer.sv
design/satd_accum.sv
design/fme_satd_8x8.sv
verification/fme_satd_8x8_asserts.sv
verification/fme_satd_8x8_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
LINTFLAGS := --lint-only --timing --assert
TOP       := fme_satd_8x8_tb
RTL_TOP   := fme_satd_8x8
FILELIST  := tb.f
BUILD_DIR := obj_dir
SIM_ARGS  := +verilator+error+limit+1000
RTL_FILES := $(filter design/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

lint:
	$(VERILATOR) $(LINTFLAGS) $(RTL_FILES) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
